// File: hw/jfive_pkg.sv
`default_nettype none

package jfive_pkg;

    localparam int XLEN = 32;

    // host register word indices.
    localparam int ADR_CORE_ID      = 0;
    localparam int ADR_CORE_VERSION = 1;
    localparam int ADR_CORE_DATE    = 2;
    localparam int ADR_MEM_OFFSET   = 4;
    localparam int ADR_MEM_SIZE     = 5;
    localparam int ADR_CTL_RESET    = 8;

    localparam logic [XLEN-1:0] CORE_ID_VALUE      = 32'hffff_8723;
    localparam logic [XLEN-1:0] CORE_VERSION_VALUE = 32'h0001_0000;
    localparam logic [XLEN-1:0] CORE_DATE_VALUE    = 32'h2022_0226;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_e;

    // major opcode field, inst[6:0].
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

endpackage

`default_nettype wire

// File: hw/jfive_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface jfive_tcm_if import jfive_pkg::*; #(
    parameter int ADDR_WIDTH = 10
);
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [3:0]            wsel;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rdata;
    logic                  busy;   // port taken by someone else this cycle.

    modport requester (output en, addr, wsel, wdata, input rdata, busy);
    modport memory (input en, addr, wsel, wdata, output rdata, busy);
endinterface

interface jfive_mmio_if import jfive_pkg::*; #(
    parameter int ADDR_WIDTH = 24
);
    logic                  en;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;   // word address.
    logic [3:0]            sel;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rdata;
    logic                  stall;

    modport core (output en, we, addr, sel, wdata, input rdata, stall);
    modport bridge (input en, we, addr, sel, wdata, output rdata, stall);
endinterface

`default_nettype wire

// File: hw/jfive_tcm.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_tcm import jfive_pkg::*; #(
    parameter int TCM_SIZE       = 4096,
    parameter int TCM_ADDR_WIDTH = 10
) (
    input wire              clk,
    jfive_tcm_if.memory     port0,
    jfive_tcm_if.memory     port1
);

    localparam int MEM_WORDS = TCM_SIZE / 4;

    logic [XLEN-1:0] mem [MEM_WORDS];

    // byte lanes from wdata where wsel is set.
    function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0] old_word,
                                              input logic [XLEN-1:0] new_word,
                                              input logic [3:0]      sel);
        logic [XLEN-1:0] word;
        word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) word[8*i +: 8] = new_word[8*i +: 8];
        end
        return word;
    endfunction

    // write-first on both ports.
    always @(posedge clk) begin
        if (port0.en) begin
            mem[port0.addr] <= merge(mem[port0.addr], port0.wdata, port0.wsel);
            port0.rdata     <= merge(mem[port0.addr], port0.wdata, port0.wsel);
        end
    end

    always @(posedge clk) begin
        if (port1.en) begin
            mem[port1.addr] <= merge(mem[port1.addr], port1.wdata, port1.wsel);
            port1.rdata     <= merge(mem[port1.addr], port1.wdata, port1.wsel);
        end
    end

    assign port0.busy = 1'b0;  // the RAM itself never refuses.
    assign port1.busy = 1'b0;

endmodule

`default_nettype wire

// File: hw/jfive_ctl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_ctl_regs import jfive_pkg::*; #(
    parameter int                        S_WB_ADR_WIDTH = 16,
    parameter bit [S_WB_ADR_WIDTH-1:0]   S_WB_TCM_ADR   = 16'h8000,
    parameter int                        TCM_SIZE       = 4096,
    parameter bit                        INIT_CTL_RESET = 1'b1
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire   [S_WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  wire   [XLEN-1:0]           s_wb_dat_i,
    input  wire   [XLEN/8-1:0]         s_wb_sel_i,
    input  wire                        s_wb_we_i,
    input  wire                        s_wb_stb_i,
    output logic  [XLEN-1:0]           s_wb_dat_o,
    output logic                       s_wb_ack_o,
    output logic                       core_reset_o
);

    logic reg_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_reset <= INIT_CTL_RESET;
        end else if (s_wb_stb_i && s_wb_we_i && s_wb_sel_i[0]
                     && s_wb_adr_i == S_WB_ADR_WIDTH'(ADR_CTL_RESET)) begin
            reg_reset <= s_wb_dat_i[0];
        end
    end

    // one cycle behind the control bit.
    always_ff @(posedge clk) begin
        if (reset) core_reset_o <= 1'b1;
        else       core_reset_o <= reg_reset;
    end

    always_comb begin
        case (int'(s_wb_adr_i))
            ADR_CORE_ID:      s_wb_dat_o = CORE_ID_VALUE;
            ADR_CORE_VERSION: s_wb_dat_o = CORE_VERSION_VALUE;
            ADR_CORE_DATE:    s_wb_dat_o = CORE_DATE_VALUE;
            ADR_MEM_OFFSET:   s_wb_dat_o = XLEN'(S_WB_TCM_ADR);
            ADR_MEM_SIZE:     s_wb_dat_o = XLEN'(TCM_SIZE);
            ADR_CTL_RESET:    s_wb_dat_o = XLEN'(reg_reset);
            default:          s_wb_dat_o = '0;
        endcase
    end

    assign s_wb_ack_o = s_wb_stb_i;  // same-cycle ack.

endmodule

`default_nettype wire

// File: hw/jfive_tcm_loader.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_tcm_loader import jfive_pkg::*; #(
    parameter int                        S_WB_ADR_WIDTH = 16,
    parameter bit [S_WB_ADR_WIDTH-1:0]   S_WB_TCM_ADR   = 16'h8000,
    parameter int                        TCM_ADDR_WIDTH = 10
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire   [S_WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  wire   [XLEN-1:0]           s_wb_dat_i,
    input  wire   [XLEN/8-1:0]         s_wb_sel_i,
    input  wire                        s_wb_we_i,
    input  wire                        s_wb_stb_i,
    jfive_tcm_if.memory                fetch,
    jfive_tcm_if.requester             port
);

    logic                      wr_en;
    logic [TCM_ADDR_WIDTH-1:0] wr_addr;
    logic [3:0]                wr_sel;
    logic [XLEN-1:0]           wr_data;

    always_ff @(posedge clk) begin
        if (reset) wr_en <= 1'b0;
        else       wr_en <= s_wb_stb_i && s_wb_we_i && s_wb_sel_i != '0
                            && s_wb_adr_i >= S_WB_TCM_ADR;
    end

    always_ff @(posedge clk) begin
        wr_addr <= TCM_ADDR_WIDTH'(s_wb_adr_i - S_WB_TCM_ADR);  // window offset.
        wr_sel  <= s_wb_sel_i;
        wr_data <= s_wb_dat_i;
    end

    // host write wins the port, fetch waits a cycle.
    assign port.en     = wr_en | fetch.en;
    assign port.addr   = wr_en ? wr_addr : fetch.addr;
    assign port.wsel   = wr_en ? wr_sel  : fetch.wsel;
    assign port.wdata  = wr_en ? wr_data : fetch.wdata;
    assign fetch.rdata = port.rdata;
    assign fetch.busy  = wr_en | port.busy;

endmodule

`default_nettype wire

// File: hw/jfive_mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_mmio_bridge import jfive_pkg::*; #(
    parameter int M_WB_ADR_WIDTH = 24
) (
    input  wire                        clk,
    jfive_mmio_if.bridge               mmio,
    input  wire   [XLEN-1:0]           m_wb_dat_i,
    input  wire                        m_wb_ack_i,
    output logic  [M_WB_ADR_WIDTH-1:0] m_wb_adr_o,
    output logic  [XLEN-1:0]           m_wb_dat_o,
    output logic  [3:0]                m_wb_sel_o,
    output logic                       m_wb_we_o,
    output logic                       m_wb_stb_o
);

    // request goes straight out.
    assign m_wb_stb_o = mmio.en;
    assign m_wb_we_o  = mmio.we;
    assign m_wb_adr_o = mmio.addr;
    assign m_wb_sel_o = mmio.sel;
    assign m_wb_dat_o = mmio.wdata;

    // core freezes until the slave answers.
    assign mmio.stall = mmio.en & ~m_wb_ack_i;

    always_ff @(posedge clk) begin
        if (mmio.en && m_wb_ack_i) begin
            mmio.rdata <= m_wb_dat_i;  // used in WRITEBACK.
        end
    end

endmodule

`default_nettype wire

// File: hw/jfive_core.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_core import jfive_pkg::*; #(
    parameter logic [XLEN-1:0] INIT_PC_ADDR     = 32'h8000_0000,
    parameter int              TCM_ADDR_WIDTH   = 10,
    parameter logic [XLEN-1:0] TCM_DECODE_MASK  = 32'hff00_0000,
    parameter logic [XLEN-1:0] TCM_DECODE_ADDR  = 32'h8000_0000,
    parameter int              MMIO_ADDR_WIDTH  = 24,
    parameter logic [XLEN-1:0] MMIO_DECODE_MASK = 32'hf000_0000,
    parameter logic [XLEN-1:0] MMIO_DECODE_ADDR = 32'h1000_0000
) (
    input  wire             clk,
    input  wire             reset,
    jfive_tcm_if.requester  itcm,
    jfive_tcm_if.requester  dtcm,
    jfive_mmio_if.core      mmio
);

    core_state_e state, next_state;
    logic [XLEN-1:0] pc, next_pc;
    logic            hold;

    logic [XLEN-1:0] rf [32];
    logic            rf_we;
    logic [4:0]      rf_wa;
    logic [XLEN-1:0] rf_wd;

    // decode, only meaningful in EXECUTE.
    logic [XLEN-1:0] inst;
    opcode_e         opcode;
    logic [4:0]      rd, rs1, rs2;
    logic [2:0]      funct3;
    logic [XLEN-1:0] rs1_val, rs2_val;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [XLEN-1:0] op_b, alu, ea, mmio_off;
    logic            taken, is_mem, hit_tcm, hit_mmio;

    // access captured in EXECUTE.
    logic [TCM_ADDR_WIDTH-1:0] mem_addr;
    logic [XLEN-1:0]           mem_wdata;
    logic [4:0]                mem_rd;
    logic                      mem_store, mem_tcm, mem_mmio;

    assign inst    = itcm.rdata;
    assign opcode  = opcode_e'(inst[6:0]);
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};

    assign op_b = (opcode == OP_REG) ? rs2_val : imm_i;

    always_comb begin
        case (funct3)
            3'b100:  alu = rs1_val ^ op_b;
            3'b110:  alu = rs1_val | op_b;
            3'b111:  alu = rs1_val & op_b;
            default: alu = (opcode == OP_REG && inst[30]) ? rs1_val - op_b : rs1_val + op_b;
        endcase
    end

    assign taken = (rs1_val == rs2_val) ^ funct3[0];  // beq / bne.

    // load/store address and region decode.
    assign ea       = rs1_val + ((opcode == OP_STORE) ? imm_s : imm_i);
    assign is_mem   = (opcode == OP_LOAD) || (opcode == OP_STORE);
    assign hit_tcm  = (ea & TCM_DECODE_MASK) == TCM_DECODE_ADDR;
    assign hit_mmio = (ea & MMIO_DECODE_MASK) == MMIO_DECODE_ADDR;
    assign mmio_off = ea - MMIO_DECODE_ADDR;

    // mmio request leaves straight from EXECUTE.
    assign mmio.en    = (state == EXECUTE) && is_mem && hit_mmio;
    assign mmio.we    = (opcode == OP_STORE);
    assign mmio.addr  = mmio_off[MMIO_ADDR_WIDTH+1:2];
    assign mmio.sel   = 4'hf;
    assign mmio.wdata = rs2_val;

    assign itcm.en    = (state == FETCH);
    assign itcm.addr  = pc[TCM_ADDR_WIDTH+1:2];
    assign itcm.wsel  = 4'h0;
    assign itcm.wdata = '0;

    assign dtcm.en    = (state == MEMORY) && mem_tcm;
    assign dtcm.addr  = mem_addr;
    assign dtcm.wsel  = mem_store ? 4'hf : 4'h0;
    assign dtcm.wdata = mem_wdata;

    assign hold = ((state == FETCH) && itcm.busy) || mmio.stall || dtcm.busy;

    always_comb begin
        next_state = state;
        next_pc    = pc + 32'd4;
        rf_we      = 1'b0;
        rf_wa      = rd;
        rf_wd      = alu;
        case (state)
            FETCH: begin
                next_state = EXECUTE;
                next_pc    = pc;
            end
            EXECUTE: begin
                next_state = FETCH;
                case (opcode)
                    OP_LUI: begin
                        rf_we = 1'b1;
                        rf_wd = imm_u;
                    end
                    OP_JAL: begin
                        rf_we   = 1'b1;
                        rf_wd   = pc + 32'd4;
                        next_pc = pc + imm_j;
                    end
                    OP_BRANCH: if (taken) next_pc = pc + imm_b;
                    OP_IMM, OP_REG: rf_we = 1'b1;
                    OP_LOAD, OP_STORE: begin
                        next_pc    = pc;  // advanced in WRITEBACK.
                        next_state = hit_tcm ? MEMORY : WRITEBACK;
                    end
                    default: ;  // unknown opcode acts as nop.
                endcase
            end
            MEMORY: begin
                next_state = WRITEBACK;
                next_pc    = pc;
            end
            default: begin
                next_state = FETCH;
                rf_we      = !mem_store;
                rf_wa      = mem_rd;
                rf_wd      = mem_tcm ? dtcm.rdata : mem_mmio ? mmio.rdata : '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= INIT_PC_ADDR;
        end else if (!hold) begin
            state <= next_state;
            pc    <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && rf_we && rf_wa != 5'd0) rf[rf_wa] <= rf_wd;
    end

    always_ff @(posedge clk) begin
        if (!hold && state == EXECUTE) begin
            mem_addr  <= ea[TCM_ADDR_WIDTH+1:2];
            mem_wdata <= rs2_val;
            mem_rd    <= rd;
            mem_store <= (opcode == OP_STORE);
            mem_tcm   <= hit_tcm;
            mem_mmio  <= hit_mmio;
        end
    end

endmodule

`default_nettype wire

// File: hw/jfive_micro_controller.sv
`timescale 1ns/1ps
`default_nettype none

module jfive_micro_controller import jfive_pkg::*; #(
    parameter int                      S_WB_ADR_WIDTH   = 16,
    parameter bit [S_WB_ADR_WIDTH-1:0] S_WB_TCM_ADR     = 16'h8000,
    parameter int                      TCM_SIZE         = 4096,
    parameter int                      M_WB_ADR_WIDTH   = 24,
    parameter logic [XLEN-1:0]         TCM_DECODE_MASK  = 32'hff00_0000,
    parameter logic [XLEN-1:0]         TCM_DECODE_ADDR  = 32'h8000_0000,
    parameter logic [XLEN-1:0]         MMIO_DECODE_MASK = 32'hf000_0000,
    parameter logic [XLEN-1:0]         MMIO_DECODE_ADDR = 32'h1000_0000,
    parameter logic [XLEN-1:0]         INIT_PC_ADDR     = 32'h8000_0000,
    parameter bit                      INIT_CTL_RESET   = 1'b1
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire   [S_WB_ADR_WIDTH-1:0] s_wb_adr_i,
    output logic  [XLEN-1:0]           s_wb_dat_o,
    input  wire   [XLEN-1:0]           s_wb_dat_i,
    input  wire   [XLEN/8-1:0]         s_wb_sel_i,
    input  wire                        s_wb_we_i,
    input  wire                        s_wb_stb_i,
    output logic                       s_wb_ack_o,
    output logic  [M_WB_ADR_WIDTH-1:0] m_wb_adr_o,
    input  wire   [XLEN-1:0]           m_wb_dat_i,
    output logic  [XLEN-1:0]           m_wb_dat_o,
    output logic  [3:0]                m_wb_sel_o,
    output logic                       m_wb_we_o,
    output logic                       m_wb_stb_o,
    input  wire                        m_wb_ack_i
);

    localparam int TCM_ADDR_WIDTH = $clog2(TCM_SIZE / 4);

    logic core_reset;

    jfive_tcm_if  #(.ADDR_WIDTH(TCM_ADDR_WIDTH)) fetch_if ();  // core to loader.
    jfive_tcm_if  #(.ADDR_WIDTH(TCM_ADDR_WIDTH)) port0_if ();  // loader to RAM.
    jfive_tcm_if  #(.ADDR_WIDTH(TCM_ADDR_WIDTH)) dtcm_if ();
    jfive_mmio_if #(.ADDR_WIDTH(M_WB_ADR_WIDTH)) mmio_if ();

    jfive_ctl_regs #(
        .S_WB_ADR_WIDTH (S_WB_ADR_WIDTH),
        .S_WB_TCM_ADR   (S_WB_TCM_ADR),
        .TCM_SIZE       (TCM_SIZE),
        .INIT_CTL_RESET (INIT_CTL_RESET)
    ) i_ctl_regs (
        .clk, .reset, .s_wb_adr_i, .s_wb_dat_i, .s_wb_sel_i, .s_wb_we_i, .s_wb_stb_i,
        .s_wb_dat_o, .s_wb_ack_o, .core_reset_o (core_reset)
    );

    jfive_tcm_loader #(
        .S_WB_ADR_WIDTH (S_WB_ADR_WIDTH),
        .S_WB_TCM_ADR   (S_WB_TCM_ADR),
        .TCM_ADDR_WIDTH (TCM_ADDR_WIDTH)
    ) i_tcm_loader (
        .clk, .reset, .s_wb_adr_i, .s_wb_dat_i, .s_wb_sel_i, .s_wb_we_i, .s_wb_stb_i,
        .fetch (fetch_if), .port (port0_if)
    );

    jfive_tcm #(
        .TCM_SIZE       (TCM_SIZE),
        .TCM_ADDR_WIDTH (TCM_ADDR_WIDTH)
    ) i_tcm (
        .clk, .port0 (port0_if), .port1 (dtcm_if)
    );

    jfive_core #(
        .INIT_PC_ADDR     (INIT_PC_ADDR),
        .TCM_ADDR_WIDTH   (TCM_ADDR_WIDTH),
        .TCM_DECODE_MASK  (TCM_DECODE_MASK),
        .TCM_DECODE_ADDR  (TCM_DECODE_ADDR),
        .MMIO_ADDR_WIDTH  (M_WB_ADR_WIDTH),
        .MMIO_DECODE_MASK (MMIO_DECODE_MASK),
        .MMIO_DECODE_ADDR (MMIO_DECODE_ADDR)
    ) i_core (
        .clk, .reset (core_reset), .itcm (fetch_if), .dtcm (dtcm_if), .mmio (mmio_if)
    );

    jfive_mmio_bridge #(
        .M_WB_ADR_WIDTH (M_WB_ADR_WIDTH)
    ) i_mmio_bridge (
        .clk, .mmio (mmio_if), .m_wb_dat_i, .m_wb_ack_i,
        .m_wb_adr_o, .m_wb_dat_o, .m_wb_sel_o, .m_wb_we_o, .m_wb_stb_o
    );

endmodule

`default_nettype wire

// File: test/tb_jfive.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jfive import jfive_pkg::*; ();

    localparam logic [31:0] PC_BASE    = 32'h8000_0000;
    localparam logic [15:0] TCM_WINDOW = 16'h8000;
    localparam int          TCM_BYTES  = 4096;
    localparam int          LIMIT      = 3000;  // cycles per wait loop.

    logic        clk;
    logic        reset;
    logic [15:0] s_wb_adr_i;
    logic [31:0] s_wb_dat_o;
    logic [31:0] s_wb_dat_i;
    logic [3:0]  s_wb_sel_i;
    logic        s_wb_we_i;
    logic        s_wb_stb_i;
    logic        s_wb_ack_o;
    logic [23:0] m_wb_adr_o;
    logic [31:0] m_wb_dat_i;
    logic [31:0] m_wb_dat_o;
    logic [3:0]  m_wb_sel_o;
    logic        m_wb_we_o;
    logic        m_wb_stb_o;
    logic        m_wb_ack_i;

    logic [15:0] lfsr = 16'd14;
    logic [31:0] rd_mem [16];     // slave read data by word address.
    logic [23:0] wr_adr_q [$];
    logic [31:0] wr_dat_q [$];
    logic [23:0] rd_adr_q [$];
    logic [31:0] rd_q [$];
    logic [23:0] exp_adr_q [$];
    logic [31:0] exp_dat_q [$];
    logic [31:0] prog [$];
    int          checks;
    int          errors;
    int          timeouts;

    jfive_micro_controller i_jfive_micro_controller (
        .clk, .reset, .s_wb_adr_i, .s_wb_dat_o, .s_wb_dat_i, .s_wb_sel_i, .s_wb_we_i,
        .s_wb_stb_i, .s_wb_ack_o, .m_wb_adr_o, .m_wb_dat_i, .m_wb_dat_o, .m_wb_sel_o,
        .m_wb_we_o, .m_wb_stb_o, .m_wb_ack_i
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic host_write(input logic [15:0] adr, input logic [31:0] dat);
        @(negedge clk);
        s_wb_adr_i = adr;
        s_wb_dat_i = dat;
        s_wb_sel_i = 4'hf;
        s_wb_we_i  = 1'b1;
        s_wb_stb_i = 1'b1;
        @(negedge clk);
        check_value("s_wb_ack_o", 32'(s_wb_ack_o), 32'd1);
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
        s_wb_sel_i = 4'h0;
    endtask

    task automatic host_read(input logic [15:0] adr, output logic [31:0] dat);
        @(negedge clk);
        s_wb_adr_i = adr;
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b1;
        @(negedge clk);
        check_value("s_wb_ack_o", 32'(s_wb_ack_o), 32'd1);
        dat        = s_wb_dat_o;
        s_wb_stb_i = 1'b0;
    endtask

    // wishbone slave with 0 to 3 cycles of ack delay.
    task automatic serve_bus();
        int delay;
        bit pending;
        pending = 1'b0;
        delay   = 0;
        forever begin
            @(negedge clk);
            if (m_wb_ack_i) begin
                m_wb_ack_i = 1'b0;
            end else if (!m_wb_stb_o) begin
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = int'(take_bits(2));
                end
                if (delay == 0) begin
                    pending    = 1'b0;
                    m_wb_ack_i = 1'b1;
                    check_value("m_wb_sel_o", 32'(m_wb_sel_o), 32'h0000_000f);  // word access.
                    if (m_wb_we_o) begin
                        wr_adr_q.push_back(m_wb_adr_o);
                        wr_dat_q.push_back(m_wb_dat_o);
                    end else begin
                        m_wb_dat_i = rd_mem[m_wb_adr_o[3:0]];
                        rd_adr_q.push_back(m_wb_adr_o);
                        rd_q.push_back(m_wb_dat_i);
                    end
                end else begin
                    delay--;
                end
            end
        end
    endtask

    task automatic new_test(input string name);
        $display("test: %s", name);
        prog.delete();
        exp_adr_q.delete();
        exp_dat_q.delete();
    endtask

    task automatic expect_write(input logic [23:0] adr, input logic [31:0] dat);
        exp_adr_q.push_back(adr);
        exp_dat_q.push_back(dat);
    endtask

    // core held in reset and bus logs emptied.
    task automatic hold_core();
        host_write(16'(ADR_CTL_RESET), 32'd1);
        repeat (3) @(negedge clk);
        wr_adr_q.delete();
        wr_dat_q.delete();
        rd_adr_q.delete();
        rd_q.delete();
    endtask

    task automatic run_program();
        hold_core();
        foreach (prog[i]) host_write(TCM_WINDOW + 16'(i), prog[i]);
        host_write(16'(ADR_CTL_RESET), 32'd0);
    endtask

    task automatic compare_writes();
        int cycles;
        cycles = 0;
        while (wr_dat_q.size() < exp_dat_q.size() && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (wr_dat_q.size() < exp_dat_q.size()) begin
            timeouts++;
            $display("timeout: only %0d of %0d bus writes seen after %0d cycles",
                     wr_dat_q.size(), exp_dat_q.size(), LIMIT);
        end
        repeat (20) @(negedge clk);  // program parks in a self loop.
        check_value("bus write count", wr_dat_q.size(), exp_dat_q.size());
        for (int i = 0; i < exp_dat_q.size() && i < wr_dat_q.size(); i++) begin
            check_value($sformatf("m_wb_adr_o[%0d]", i), 32'(wr_adr_q[i]), 32'(exp_adr_q[i]));
            check_value($sformatf("m_wb_dat_o[%0d]", i), wr_dat_q[i], exp_dat_q[i]);
        end
    endtask

    task automatic read_host_registers();
        logic [31:0] v;
        int          unmapped [5] = '{3, 6, 7, 9, 15};
        new_test("host registers");
        host_read(16'(ADR_CORE_ID), v);
        check_value("core id", v, CORE_ID_VALUE);
        host_read(16'(ADR_CORE_VERSION), v);
        check_value("core version", v, CORE_VERSION_VALUE);
        host_read(16'(ADR_CORE_DATE), v);
        check_value("core date", v, CORE_DATE_VALUE);
        host_read(16'(ADR_MEM_OFFSET), v);
        check_value("mem offset", v, 32'(TCM_WINDOW));
        host_read(16'(ADR_MEM_SIZE), v);
        check_value("mem size", v, TCM_BYTES);
        foreach (unmapped[i]) begin
            host_read(16'(unmapped[i]), v);
            check_value($sformatf("unmapped word %0d", unmapped[i]), v, 32'd0);
        end
        @(negedge clk);
        check_value("s_wb_ack_o idle", 32'(s_wb_ack_o), 32'd0);
    endtask

    task automatic toggle_core_reset();
        logic [31:0] v;
        int          cycles;
        int          strobes;
        new_test("core reset control");
        host_read(16'(ADR_CTL_RESET), v);
        check_value("ctl reset after reset", v, 32'd1);
        prog.push_back(lui(1, 20'h10000));
        prog.push_back(sw(0, 1, 12'h000));
        prog.push_back(jal(0, -4));
        run_program();
        host_read(16'(ADR_CTL_RESET), v);
        check_value("ctl reset released", v, 32'd0);
        cycles = 0;
        while (!m_wb_stb_o && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!m_wb_stb_o) begin
            timeouts++;
            $display("timeout: no bus strobe after the core was released");
        end
        hold_core();
        host_read(16'(ADR_CTL_RESET), v);
        check_value("ctl reset held", v, 32'd1);
        strobes = 0;
        repeat (50) begin
            @(negedge clk);
            if (m_wb_stb_o) strobes++;
        end
        check_value("strobes while held", strobes, 32'd0);
    endtask

    task automatic alu_program();
        logic [31:0] a;
        logic [31:0] b;
        new_test("arithmetic");
        a = 32'h1234_5000 + 32'h0000_0678;
        b = 32'hffff_ff00;             // sign-extended 0xf00.
        prog.push_back(lui(1, 20'h10000));
        prog.push_back(lui(2, 20'h12345));
        prog.push_back(addi(2, 2, 12'h678));
        prog.push_back(addi(3, 0, 12'hf00));
        prog.push_back(alu_rr(7'h00, 3'b000, 4, 2, 3));
        prog.push_back(alu_rr(7'h20, 3'b000, 5, 2, 3));
        prog.push_back(alu_rr(7'h00, 3'b111, 6, 2, 3));
        prog.push_back(alu_rr(7'h00, 3'b110, 7, 2, 3));
        prog.push_back(alu_rr(7'h00, 3'b100, 8, 2, 3));
        prog.push_back(lui(9, 20'habcde));
        for (int r = 2; r <= 9; r++) prog.push_back(sw(5'(r), 1, 12'(4 * (r - 2))));
        prog.push_back(jal(0, 0));
        expect_write(0, a);
        expect_write(1, b);
        expect_write(2, a + b);
        expect_write(3, a - b);
        expect_write(4, a & b);
        expect_write(5, a | b);
        expect_write(6, a ^ b);
        expect_write(7, 32'habcd_e000);
        run_program();
        compare_writes();
    endtask

    task automatic tcm_round_trip();
        new_test("tcm data path");
        prog.push_back(lui(1, 20'h10000));
        prog.push_back(lui(2, 20'h80000));
        prog.push_back(lui(3, 20'hcafe1));
        prog.push_back(addi(3, 3, 12'h2b4));
        prog.push_back(addi(6, 0, 12'h055));
        prog.push_back(sw(3, 2, 12'h200));
        prog.push_back(sw(6, 2, 12'h204));
        prog.push_back(lw(4, 2, 12'h200));
        prog.push_back(lw(7, 2, 12'h204));
        prog.push_back(sw(4, 1, 12'h000));
        prog.push_back(sw(7, 1, 12'h004));
        prog.push_back(jal(0, 0));
        expect_write(0, 32'hcafe_1000 + 32'h0000_02b4);
        expect_write(1, 32'h0000_0055);
        run_program();
        compare_writes();
    endtask

    task automatic mmio_load_increment();
        new_test("mmio loads with random ack delay");
        for (int i = 0; i < 16; i++) rd_mem[i] = take_bits(32);
        rd_mem[3] = 32'hffff_ffff;     // wraps to zero.
        prog.push_back(lui(1, 20'h10000));
        for (int i = 0; i < 6; i++) begin
            prog.push_back(lw(2, 1, 12'(64 + 4 * i)));
            prog.push_back(addi(2, 2, 12'h001));
            prog.push_back(sw(2, 1, 12'(128 + 4 * i)));
            expect_write(24'(32 + i), rd_mem[i] + 32'd1);
        end
        prog.push_back(jal(0, 0));
        run_program();
        compare_writes();
        check_value("bus read count", rd_q.size(), 32'd6);
        for (int i = 0; i < rd_adr_q.size() && i < 6; i++) begin
            check_value($sformatf("m_wb_adr_o read %0d", i), 32'(rd_adr_q[i]),
                        32'((64 + 4 * i) >> 2));
        end
        for (int i = 0; i < rd_q.size() && i < wr_dat_q.size(); i++) begin
            check_value($sformatf("write %0d vs read", i), wr_dat_q[i], rd_q[i] + 32'd1);
        end
    endtask

    task automatic branch_loop_restart();
        int sum;
        new_test("branch loop and restart");
        sum = 0;
        for (int k = 1; k <= 10; k++) sum += k;
        prog.push_back(lui(1, 20'h10000));
        prog.push_back(addi(2, 0, 12'h000));
        prog.push_back(addi(3, 0, 12'h001));
        prog.push_back(addi(4, 0, 12'd11));
        prog.push_back(addi(6, 0, 12'h003));
        prog.push_back(alu_rr(7'h00, 3'b000, 2, 2, 3));  // loop head, word 5.
        prog.push_back(addi(3, 3, 12'h001));
        prog.push_back(branch(3'b001, 3, 4, -8));
        prog.push_back(jal(5, 8));
        prog.push_back(addi(2, 0, 12'h000));             // skipped.
        prog.push_back(sw(2, 1, 12'h000));
        prog.push_back(sw(5, 1, 12'h004));
        prog.push_back(branch(3'b000, 3, 4, 8));
        prog.push_back(addi(6, 0, 12'h007));             // skipped.
        prog.push_back(sw(6, 1, 12'h008));
        prog.push_back(jal(0, 0));
        expect_write(0, sum);
        expect_write(1, PC_BASE + 32'd36);               // link of the jal at word 8.
        expect_write(2, 32'd3);
        run_program();
        compare_writes();
        hold_core();
        host_write(16'(ADR_CTL_RESET), 32'd0);
        compare_writes();
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        s_wb_adr_i = '0;
        s_wb_dat_i = '0;
        s_wb_sel_i = '0;
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b0;
        m_wb_dat_i = '0;
        m_wb_ack_i = 1'b0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        for (int i = 0; i < 16; i++) rd_mem[i] = {28'hd00d_000, i[3:0]};
        repeat (2) @(negedge clk);
        reset = 1'b0;
        read_host_registers();
        toggle_core_reset();
        alu_program();
        tcm_round_trip();
        mmio_load_increment();
        branch_loop_restart();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial serve_bus();

endmodule

`default_nettype wire

// File: sim.f
hw/jfive_pkg.sv
hw/jfive_bus_if.sv
hw/jfive_tcm.sv
hw/jfive_ctl_regs.sv
hw/jfive_tcm_loader.sv
hw/jfive_mmio_bridge.sv
hw/jfive_core.sv
hw/jfive_micro_controller.sv
test/tb_jfive.sv

// File: Bender.yml
package:
  name: jfive

sources:
  - hw/jfive_pkg.sv
  - hw/jfive_bus_if.sv
  - hw/jfive_tcm.sv
  - hw/jfive_ctl_regs.sv
  - hw/jfive_tcm_loader.sv
  - hw/jfive_mmio_bridge.sv
  - hw/jfive_core.sv
  - hw/jfive_micro_controller.sv
  - target: test
    files:
      - test/tb_jfive.sv
